/* Makefile */
VERILATOR  ?= verilator
TB_TOP     ?= tb_id_display
RTL_TOP    ?= id_display_top
FILE_LIST  ?= files.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -Wno-fatal -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TB_TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR)

/* common/id_code_pkg.sv */
`default_nettype none

package id_code_pkg;

    // Address bit currently shown on the strip, wraps modulo 8
    typedef logic [2:0] bit_sel_t;

    // Index-0 requests seen since the last bit change
    typedef enum logic [1:0] {
        SEEN_NONE,
        SEEN_ONE,
        SETTLED
    } settle_state_t;

endpackage

`default_nettype wire

/* common/led_color_bus.sv */
`timescale 1ns/100ps
`default_nettype none

// Wishbone classic link, LED index out and color back
interface led_color_bus import led_strip_pkg::*; ();

    logic       cyc;
    logic       stb;
    led_index_t adr;
    led_color_t dat;
    logic       ack;

    modport master (
        output cyc,
        output stb,
        output adr,
        input  dat,
        input  ack
    );

    modport slave (
        input  cyc,
        input  stb,
        input  adr,
        output dat,
        output ack
    );

endinterface

`default_nettype wire

/* common/led_strip_pkg.sv */
`default_nettype none

package led_strip_pkg;

    // Bits sent to each LED, green first
    localparam int COLOR_BITS = 24;

    // LED index as carried on the color bus
    typedef logic [15:0] led_index_t;

    typedef struct packed {
        logic [7:0] green;
        logic [7:0] red;
        logic [7:0] blue;
    } led_channels_t;

    // Same 24 bits seen per channel or as the serial word, MSB first
    typedef union packed {
        led_channels_t         ch;
        logic [COLOR_BITS-1:0] raw;
    } led_color_t;

endpackage

`default_nettype wire

/* files.f */
common/led_strip_pkg.sv
common/id_code_pkg.sv
common/led_color_bus.sv
source/debouncer.sv
source/id_shower.sv
led_driver/led_frame_sequencer.sv
led_driver/ws2812_serializer.sv
source/id_display_top.sv
testbench/tb_id_display.sv

/* led_driver/led_frame_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module led_frame_sequencer import led_strip_pkg::*; #(
    parameter int NUM_LEDS   = 50,
    parameter int LATCH_CLKS = 28000
) (
    input  logic         clk,
    input  logic         rst,
    led_color_bus.master bus,
    output logic         word_valid,
    output led_color_t   word,
    input  logic         ready,
    output logic         latch_active
);
    localparam int         ADDR_W     = (NUM_LEDS > 1) ? $clog2(NUM_LEDS) : 1;
    localparam int         LATCH_W    = $clog2(LATCH_CLKS + 1);
    localparam led_index_t LAST_INDEX = led_index_t'(NUM_LEDS - 1);

    logic               word_last;
    logic               fetch_hold;
    logic               draining;
    logic [LATCH_W-1:0] latch_cnt;
    logic               transfer;
    logic               start_fetch;

    if (ADDR_W > $bits(led_index_t)) begin : g_addr_check
        $error("NUM_LEDS does not fit the bus index");
    end

    assign transfer    = word_valid && ready;
    // Prefetch as soon as the holding register is free
    assign start_fetch = !bus.cyc && !word_valid && !fetch_hold;

    always_ff @(posedge clk) begin
        if (rst) begin
            bus.cyc      <= 1'b0;
            bus.stb      <= 1'b0;
            bus.adr      <= '0;
            word_valid   <= 1'b0;
            word_last    <= 1'b0;
            fetch_hold   <= 1'b0;
            draining     <= 1'b0;
            latch_active <= 1'b0;
            latch_cnt    <= '0;
        end else begin
            if (start_fetch) begin
                bus.cyc <= 1'b1;
                bus.stb <= 1'b1;
            end else if (bus.ack) begin
                bus.cyc    <= 1'b0;
                bus.stb    <= 1'b0;
                bus.adr    <= (bus.adr == LAST_INDEX) ? '0 : bus.adr + 1'b1;
                word_valid <= 1'b1;
                word_last  <= (bus.adr == LAST_INDEX);
                // No more requests after the last LED until the gap ends
                if (bus.adr == LAST_INDEX) begin
                    fetch_hold <= 1'b1;
                end
            end else if (transfer) begin
                word_valid <= 1'b0;
            end
            if (transfer && word_last) begin
                draining <= 1'b1;
            end else if (draining && ready) begin
                draining     <= 1'b0;
                latch_active <= 1'b1;
                latch_cnt    <= '0;
            end
            if (latch_active) begin
                if (latch_cnt == LATCH_W'(LATCH_CLKS - 1)) begin
                    latch_active <= 1'b0;
                    fetch_hold   <= 1'b0;
                end else begin
                    latch_cnt <= latch_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.ack) begin
            word <= bus.dat;
        end
    end

    // A second reply in a row would overwrite the held word
    ack_single: assert property (@(posedge clk) disable iff (rst)
        bus.ack |=> !bus.ack);

endmodule

`default_nettype wire

/* led_driver/ws2812_serializer.sv */
`timescale 1ns/100ps
`default_nettype none

module ws2812_serializer import led_strip_pkg::*; #(
    parameter int T0H_CLKS = 40,
    parameter int T1H_CLKS = 80,
    parameter int BIT_CLKS = 125
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       word_valid,
    input  led_color_t word,
    input  logic       latch_active,
    output logic       ready,
    output logic       data_out
);
    localparam int CYC_W = $clog2(BIT_CLKS);
    localparam int BIT_W = $clog2(COLOR_BITS);

    led_color_t       shift_reg;
    logic             busy;
    logic [BIT_W-1:0] bit_cnt;
    logic [CYC_W-1:0] cyc_cnt;
    logic             bit_end;
    logic             word_end;

    if (!(T0H_CLKS < T1H_CLKS && T1H_CLKS < BIT_CLKS)) begin : g_timing_check
        $error("Pulse widths must satisfy T0H < T1H < BIT");
    end

    assign bit_end  = (cyc_cnt == CYC_W'(BIT_CLKS - 1));
    assign word_end = busy && bit_end && (bit_cnt == BIT_W'(COLOR_BITS - 1));

    // Accept the next word in the last cycle so bits run back to back
    assign ready = !busy || word_end;

    // High part of each bit, its width set by the current MSB
    assign data_out = busy && !latch_active &&
        (cyc_cnt < (shift_reg.raw[COLOR_BITS-1] ? CYC_W'(T1H_CLKS) : CYC_W'(T0H_CLKS)));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            cyc_cnt <= '0;
        end else if (word_valid && ready) begin
            busy    <= 1'b1;
            bit_cnt <= '0;
            cyc_cnt <= '0;
        end else if (busy) begin
            if (bit_end) begin
                cyc_cnt <= '0;
                if (word_end) begin
                    busy <= 1'b0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                cyc_cnt <= cyc_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (word_valid && ready) begin
            shift_reg <= word;
        end else if (busy && bit_end) begin
            shift_reg.raw <= {shift_reg.raw[COLOR_BITS-2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

/* source/debouncer.sv */
`timescale 1ns/100ps
`default_nettype none

module debouncer #(
    parameter int DEBOUNCE_CLKS = 1000000
) (
    input  logic clk,
    input  logic rst,
    input  logic button,
    output logic level
);
    localparam int CNT_W = $clog2(DEBOUNCE_CLKS + 1);

    logic             sync_meta;
    logic             sync_btn;
    logic [CNT_W-1:0] stable_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            sync_meta  <= 1'b0;
            sync_btn   <= 1'b0;
            stable_cnt <= '0;
            level      <= 1'b0;
        end else begin
            sync_meta <= button;
            sync_btn  <= sync_meta;
            // Count only while the input disagrees with the output
            if (sync_btn == level) begin
                stable_cnt <= '0;
            end else if (stable_cnt == CNT_W'(DEBOUNCE_CLKS - 1)) begin
                stable_cnt <= '0;
                level      <= sync_btn;
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/id_display_top.sv */
`timescale 1ns/100ps
`default_nettype none

module id_display_top import led_strip_pkg::*, id_code_pkg::*; #(
    parameter int NUM_LEDS      = 50,
    parameter int T0H_CLKS      = 40,
    parameter int T1H_CLKS      = 80,
    parameter int BIT_CLKS      = 125,
    parameter int LATCH_CLKS    = 28000,
    parameter int DEBOUNCE_CLKS = 1000000
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       btn_up,
    input  logic       btn_down,
    output logic       data_out,
    output logic       frame_settled,
    output logic [2:0] bit_select
);
    logic       up_level;
    logic       down_level;
    logic       word_valid;
    led_color_t word;
    logic       ser_ready;
    logic       latch_active;
    bit_sel_t   shown_bit;

    led_color_bus color_bus ();

    assign bit_select = shown_bit;

    debouncer #(.DEBOUNCE_CLKS(DEBOUNCE_CLKS)) i_up_debounce (
        .clk    (clk),
        .rst    (rst),
        .button (btn_up),
        .level  (up_level)
    );

    debouncer #(.DEBOUNCE_CLKS(DEBOUNCE_CLKS)) i_down_debounce (
        .clk    (clk),
        .rst    (rst),
        .button (btn_down),
        .level  (down_level)
    );

    id_shower #(.NUM_LEDS(NUM_LEDS)) i_shower (
        .clk           (clk),
        .rst           (rst),
        .increment     (up_level),
        .decrement     (down_level),
        .bus           (color_bus.slave),
        .bit_select    (shown_bit),
        .frame_settled (frame_settled)
    );

    led_frame_sequencer #(
        .NUM_LEDS   (NUM_LEDS),
        .LATCH_CLKS (LATCH_CLKS)
    ) i_sequencer (
        .clk          (clk),
        .rst          (rst),
        .bus          (color_bus.master),
        .word_valid   (word_valid),
        .word         (word),
        .ready        (ser_ready),
        .latch_active (latch_active)
    );

    ws2812_serializer #(
        .T0H_CLKS (T0H_CLKS),
        .T1H_CLKS (T1H_CLKS),
        .BIT_CLKS (BIT_CLKS)
    ) i_serializer (
        .clk          (clk),
        .rst          (rst),
        .word_valid   (word_valid),
        .word         (word),
        .latch_active (latch_active),
        .ready        (ser_ready),
        .data_out     (data_out)
    );

endmodule

`default_nettype wire

/* source/id_shower.sv */
`timescale 1ns/100ps
`default_nettype none

module id_shower import led_strip_pkg::*, id_code_pkg::*; #(
    parameter int NUM_LEDS = 50
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        increment,
    input  logic        decrement,
    led_color_bus.slave bus,
    output bit_sel_t    bit_select,
    output logic        frame_settled
);
    localparam int ADDR_W = (NUM_LEDS > 1) ? $clog2(NUM_LEDS) : 1;

    logic          prev_increment;
    logic          prev_decrement;
    logic          up_edge;
    logic          down_edge;
    logic          any_edge;
    logic          request;
    logic          shown_bit;
    led_color_t    reply;
    settle_state_t settle_state;

    assign up_edge   = increment && !prev_increment;
    assign down_edge = decrement && !prev_decrement;
    assign any_edge  = up_edge || down_edge;

    // New request not yet answered
    assign request = bus.cyc && bus.stb && !bus.ack;

    // Bits above the address width are always 0
    assign shown_bit = (int'(bit_select) < ADDR_W) ? bus.adr[bit_select] : 1'b0;

    always_comb begin
        reply.ch.green = 8'h00;
        reply.ch.red   = shown_bit ? 8'h00 : 8'hFF;
        reply.ch.blue  = shown_bit ? 8'hFF : 8'h00;
    end

    assign frame_settled = (settle_state == SETTLED);

    always_ff @(posedge clk) begin
        if (rst) begin
            prev_increment <= 1'b0;
            prev_decrement <= 1'b0;
            bit_select     <= '0;
            settle_state   <= SEEN_NONE;
            bus.ack        <= 1'b0;
        end else begin
            prev_increment <= increment;
            prev_decrement <= decrement;
            // A button edge takes this cycle and the reply waits one more
            bus.ack <= request && !any_edge;
            if (up_edge) begin
                bit_select <= bit_select + 1'b1;
            end else if (down_edge) begin
                bit_select <= bit_select - 1'b1;
            end
            if (any_edge) begin
                settle_state <= SEEN_NONE;
            end else if (request && bus.adr == '0) begin
                case (settle_state)
                    SEEN_NONE: settle_state <= SEEN_ONE;
                    SEEN_ONE:  settle_state <= SETTLED;
                    SETTLED:   settle_state <= SETTLED;
                    default:   settle_state <= SEEN_NONE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (request && !any_edge) begin
            bus.dat <= reply;
        end
    end

    ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        bus.ack |-> bus.cyc && bus.stb);

    // The master keeps the index steady until the reply
    adr_hold: assert property (@(posedge clk) disable iff (rst)
        bus.stb && !bus.ack |=> $stable(bus.adr));

endmodule

`default_nettype wire

/* testbench/tb_id_display.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_id_display import led_strip_pkg::*, id_code_pkg::*; ();

    localparam int NUM_LEDS      = 12;
    localparam int T0H_CLKS      = 2;
    localparam int T1H_CLKS      = 5;
    localparam int BIT_CLKS      = 8;
    localparam int LATCH_CLKS    = 40;
    localparam int DEBOUNCE_CLKS = 4;
    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CLKS    = 16;
    localparam int NUM_FRAMES    = 30;
    localparam int ADDR_W        = $clog2(NUM_LEDS);
    // A high pulse longer than this is a 1
    localparam int ONE_MIN_CLKS  = 3;
    localparam int FRAME_CLKS    = NUM_LEDS * COLOR_BITS * BIT_CLKS + LATCH_CLKS + 4 * BIT_CLKS;
    localparam int TIMEOUT_CLKS  = NUM_FRAMES * FRAME_CLKS * 2;

    logic       clk;
    logic       rst;
    logic       btn_up;
    logic       btn_down;
    logic       data_out;
    logic       frame_settled;
    logic [2:0] bit_select;

    integer     seed;
    int         error_count;

    // Reference model
    bit_sel_t   model_bit;
    int         frames_since_change;

    // Pulse-line decoder
    int                    frames_decoded;
    int                    high_run;
    int                    low_run;
    logic                  frame_active;
    int                    word_idx;
    int                    bit_in_word;
    logic [COLOR_BITS-1:0] shift_word;
    led_color_t            frame_words [NUM_LEDS];

    id_display_top #(
        .NUM_LEDS      (NUM_LEDS),
        .T0H_CLKS      (T0H_CLKS),
        .T1H_CLKS      (T1H_CLKS),
        .BIT_CLKS      (BIT_CLKS),
        .LATCH_CLKS    (LATCH_CLKS),
        .DEBOUNCE_CLKS (DEBOUNCE_CLKS)
    ) i_dut (
        .clk           (clk),
        .rst           (rst),
        .btn_up        (btn_up),
        .btn_down      (btn_down),
        .data_out      (data_out),
        .frame_settled (frame_settled),
        .bit_select    (bit_select)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
        end
    end

    task automatic fail_run(input string reason);
        error_count++;
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_color(input string name, input led_color_t expected,
                               input led_color_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("MISMATCH %s expected %06h actual %06h",
                               name, expected.raw, actual.raw));
        end
    endtask

    task automatic check_bit(input string name, input bit_sel_t expected,
                             input bit_sel_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("MISMATCH %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            fail_run($sformatf("MISMATCH %s expected %b actual %b", name, expected, actual));
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            fail_run($sformatf("MISMATCH %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    // Red when the shown bit of the index is 0, blue when it is 1
    function automatic led_color_t expected_color(input int index, input bit_sel_t sel);
        led_color_t color;
        logic       is_blue;
        is_blue = 1'b0;
        if (int'(sel) < ADDR_W) begin
            is_blue = ((index >> sel) & 1) != 0;
        end
        color.ch.green = 8'h00;
        color.ch.red   = is_blue ? 8'h00 : 8'hFF;
        color.ch.blue  = is_blue ? 8'hFF : 8'h00;
        return color;
    endfunction

    function automatic int random_between(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    task automatic start_frame();
        if (frames_decoded > 0 && low_run < LATCH_CLKS) begin
            fail_run($sformatf("Latch gap before frame %0d lasted %0d cycles, less than %0d",
                               frames_decoded + 1, low_run, LATCH_CLKS));
        end
        frame_active = 1'b1;
        word_idx     = 0;
        bit_in_word  = 0;
    endtask

    task automatic store_bit(input logic value);
        shift_word = {shift_word[COLOR_BITS-2:0], value};
        bit_in_word++;
        if (bit_in_word == COLOR_BITS) begin
            if (word_idx < NUM_LEDS) begin
                frame_words[word_idx].raw = shift_word;
            end
            word_idx++;
            bit_in_word = 0;
        end
    endtask

    task automatic finish_frame();
        string tag;
        frame_active = 1'b0;
        frames_decoded++;
        frames_since_change++;
        tag = $sformatf("frame %0d", frames_decoded);
        if (bit_in_word != 0) begin
            fail_run($sformatf("Frame %0d ended after %0d bits of a word",
                               frames_decoded, bit_in_word));
        end
        check_count({tag, " word count"}, NUM_LEDS, word_idx);
        for (int i = 0; i < NUM_LEDS; i++) begin
            check_color($sformatf("%s led %0d", tag, i), expected_color(i, model_bit),
                        frame_words[i]);
        end
        check_bit({tag, " bit_select"}, model_bit, bit_select);
        check_flag({tag, " frame_settled"}, frames_since_change >= 2, frame_settled);
    endtask

    // Times pulses on the data line and rebuilds each frame
    initial begin : line_decoder
        frames_decoded = 0;
        high_run       = 0;
        low_run        = 0;
        frame_active   = 1'b0;
        word_idx       = 0;
        bit_in_word    = 0;
        shift_word     = '0;
        forever begin
            @(negedge clk);
            if (rst) begin
                high_run = 0;
                low_run  = 0;
            end else if (data_out) begin
                if (!frame_active) begin
                    start_frame();
                end
                high_run++;
                low_run = 0;
            end else begin
                if (high_run > 0) begin
                    store_bit(high_run > ONE_MIN_CLKS);
                end
                high_run = 0;
                low_run++;
                if (frame_active && low_run == BIT_CLKS + 1) begin
                    finish_frame();
                end
            end
        end
    end

    task automatic hold_button(input logic up, input int cycles);
        if (up) begin
            btn_up = 1'b1;
        end else begin
            btn_down = 1'b1;
        end
        repeat (cycles) @(negedge clk);
        btn_up   = 1'b0;
        btn_down = 1'b0;
    endtask

    // Bursts of pulses, each too short to pass the debouncer
    task automatic glitch_button(input logic up);
        int pulses;
        pulses = random_between(1, 3);
        for (int p = 0; p < pulses; p++) begin
            hold_button(up, random_between(1, DEBOUNCE_CLKS - 1));
            repeat (random_between(1, 3)) @(negedge clk);
        end
    endtask

    // Runs in the latch gap, so the edge lands before the next index-0 fetch
    task automatic apply_action();
        int   action;
        logic up;
        action = random_between(0, 5);
        up     = (random_between(0, 1) == 1);
        repeat (random_between(0, 7)) @(negedge clk);
        if (action < 4) begin
            up = (action < 2);
            model_bit = up ? model_bit + 1'b1 : model_bit - 1'b1;
            frames_since_change = 0;
            hold_button(up, random_between(DEBOUNCE_CLKS + 2, DEBOUNCE_CLKS + 16));
        end else if (action == 4) begin
            glitch_button(up);
        end
    endtask

    initial begin : stimulus
        seed                = 32'h31b12f69;
        error_count         = 0;
        model_bit           = '0;
        frames_since_change = 0;
        rst                 = 1'b1;
        btn_up              = 1'b0;
        btn_down            = 1'b0;
        repeat (RESET_CLKS) @(negedge clk);
        check_bit("reset bit_select", '0, bit_select);
        check_flag("reset frame_settled", 1'b0, frame_settled);
        check_flag("reset data_out", 1'b0, data_out);
        rst = 1'b0;
        for (int frame = 1; frame <= NUM_FRAMES; frame++) begin
            while (frames_decoded < frame) @(posedge clk);
            @(negedge clk);
            if (frame < NUM_FRAMES) begin
                apply_action();
            end
        end
        if (error_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            fail_run("Checks reported errors during the run");
        end
    end

    initial begin : watchdog
        repeat (RESET_CLKS + TIMEOUT_CLKS) @(posedge clk);
        fail_run($sformatf("Timeout, only %0d of %0d frames were decoded",
                           frames_decoded, NUM_FRAMES));
    end

endmodule

`default_nettype wire
